// File: design/data_sram.sv
/*
 * data RAM
 * single-port doubleword array with byte-masked writes and a
 * registered read, acknowledging each request in the next cycle
 */
`timescale 1ns/1ns

module data_sram #(
    parameter int ram_words = 512
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           req,
    input  logic                           we,
    input  logic [mem_stage_pkg::xlen-1:0] addr,
    input  logic [mem_stage_pkg::xlen-1:0] wdata,
    input  logic [7:0]                     wmask,
    output logic                           ack,
    output logic [mem_stage_pkg::xlen-1:0] rdata
);

    import mem_stage_pkg::*;

    // word index bits above the byte offset
    localparam int idx_w = $clog2(ram_words);

    logic [xlen-1:0]  mem [ram_words];
    logic [idx_w-1:0] idx;

    assign idx = addr[3 +: idx_w];

    // write path, one enable per byte lane
    always_ff @(posedge clk) begin
        if (req && we) begin
            for (int i = 0; i < 8; i++) begin
                if (wmask[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // read word stays put until the next read request
    always_ff @(posedge clk) begin
        if (req && !we) begin
            rdata <= mem[idx];
        end
    end

    // ack is a single-cycle pulse after each request
    always_ff @(posedge clk) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    // the requester must drop req while its access is acknowledged
    a_no_req_during_ack: assert property (
        @(posedge clk) disable iff (rst)
        ack |-> !req
    );

endmodule

// File: design/load_align.sv
/*
 * load data alignment
 * picks the addressed byte, half or word out of the returned
 * doubleword and sign- or zero-extends it to the register width
 */
`timescale 1ns/1ns

module load_align (
    input  logic [2:0]                     addr,
    input  logic [mem_stage_pkg::xlen-1:0] rdata,
    input  logic [2:0]                     funct3,
    output logic [mem_stage_pkg::xlen-1:0] load_value
);

    import mem_stage_pkg::*;

    // addressed byte brought down to lane 0
    logic [xlen-1:0] lane;

    assign lane = rdata >> {addr, 3'b000};

    always_comb begin
        case (funct3)
            // signed, copy the top bit of the field
            f3_b: begin
                load_value = {{(xlen-8){lane[7]}}, lane[7:0]};
            end
            f3_h: begin
                load_value = {{(xlen-16){lane[15]}}, lane[15:0]};
            end
            f3_w: begin
                load_value = {{(xlen-32){lane[31]}}, lane[31:0]};
            end
            f3_d: begin
                load_value = lane;
            end
            // unsigned, zero fill
            f3_bu: begin
                load_value = {{(xlen-8){1'b0}}, lane[7:0]};
            end
            f3_hu: begin
                load_value = {{(xlen-16){1'b0}}, lane[15:0]};
            end
            f3_wu: begin
                load_value = {{(xlen-32){1'b0}}, lane[31:0]};
            end
            default: begin
                load_value = '0;
            end
        endcase
    end

endmodule

// File: design/mem_stage_pkg.sv
/*
 * memory-stage shared definitions
 * data width, one-hot opcode-type bit positions, load/store funct3 codes
 * and the mask of opcode types that write a general-purpose register
 */
package mem_stage_pkg;

    // data and address width
    localparam int xlen = 64;

    // one-hot opcode-type vector from decode
    localparam int op_type_w = 15;

    // positions inside the opcode-type vector
    localparam int opt_load      = 5;
    localparam int opt_store     = 6;
    localparam int opt_move_src2 = 11;

    // types that end in a register write
    // alu, imm, upper-imm, jumps, loads and move-src2
    localparam logic [op_type_w-1:0] gpr_write_mask = 15'h0faf;

    // funct3 access size, low two bits give log2 of the byte count
    localparam logic [2:0] f3_b  = 3'd0;
    localparam logic [2:0] f3_h  = 3'd1;
    localparam logic [2:0] f3_w  = 3'd2;
    localparam logic [2:0] f3_d  = 3'd3;

    // unsigned load variants, zero fill
    localparam logic [2:0] f3_bu = 3'd4;
    localparam logic [2:0] f3_hu = 3'd5;
    localparam logic [2:0] f3_wu = 3'd6;

endpackage

// File: design/mem_stage_reg.sv
/*
 * EX/MEM stage register
 * holds one execute record, keeps it while the stage stalls, and
 * forwards the writeback value onto the store operand
 */
`timescale 1ns/1ns

module mem_stage_reg (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 advance,
    input  logic                                 in_valid,
    input  logic [mem_stage_pkg::xlen-1:0]       pc,
    input  logic [31:0]                          inst,
    input  logic [mem_stage_pkg::op_type_w-1:0]  opcode_type,
    input  logic [2:0]                           funct3,
    input  logic [4:0]                           rd,
    input  logic [4:0]                           rs2,
    input  logic [mem_stage_pkg::xlen-1:0]       alu_out,
    input  logic [mem_stage_pkg::xlen-1:0]       src2,
    input  logic                                 wb_writing_gpr,
    input  logic [4:0]                           wb_rd,
    input  logic [mem_stage_pkg::xlen-1:0]       wb_wdata,
    output logic                                 st_valid,
    output logic [mem_stage_pkg::xlen-1:0]       st_pc,
    output logic [31:0]                          st_inst,
    output logic [mem_stage_pkg::op_type_w-1:0]  st_opcode_type,
    output logic [2:0]                           st_funct3,
    output logic [4:0]                           st_rd,
    output logic [mem_stage_pkg::xlen-1:0]       st_alu_out,
    output logic [mem_stage_pkg::xlen-1:0]       st_src2
);

    import mem_stage_pkg::*;

    // operand as captured from execute, before forwarding
    logic [xlen-1:0] src2_q;
    logic [4:0]      rs2_q;
    logic            rs2_hit;

    // control fields, a reset leaves a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            st_valid       <= 1'b0;
            st_opcode_type <= '0;
            st_rd          <= '0;
            rs2_q          <= '0;
        end else if (advance) begin
            // bubble when execute has nothing
            st_valid       <= in_valid;
            st_opcode_type <= opcode_type;
            st_rd          <= rd;
            rs2_q          <= rs2;
        end
    end

    // payload fields
    always_ff @(posedge clk) begin
        if (advance) begin
            st_pc      <= pc;
            st_inst    <= inst;
            st_funct3  <= funct3;
            st_alu_out <= alu_out;
            src2_q     <= src2;
        end
    end

    // writeback is writing the register this record reads as rs2
    // x0 never forwards
    assign rs2_hit = wb_writing_gpr && (wb_rd == rs2_q) && (rs2_q != 5'd0);

    assign st_src2 = rs2_hit ? wb_wdata : src2_q;

    // decode hands over at most one opcode type per record
    a_op_type_onehot: assert property (
        @(posedge clk) disable iff (rst)
        st_valid |-> $onehot0(st_opcode_type)
    );

endmodule

// File: design/mem_stage_top.sv
/*
 * memory-access stage top
 * stage register, store and load alignment, data RAM and writeback
 * select, plus the request/done control for fixed one-cycle memory
 */
`timescale 1ns/1ns

module mem_stage_top #(
    parameter int ram_words = 512
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 in_valid,
    output logic                                 in_ready,
    input  logic [mem_stage_pkg::xlen-1:0]       pc,
    input  logic [31:0]                          inst,
    input  logic [mem_stage_pkg::op_type_w-1:0]  opcode_type,
    input  logic [2:0]                           funct3,
    input  logic [4:0]                           rd,
    input  logic [4:0]                           rs2,
    input  logic [mem_stage_pkg::xlen-1:0]       alu_out,
    input  logic [mem_stage_pkg::xlen-1:0]       src2,
    output logic                                 out_valid,
    input  logic                                 out_ready,
    output logic [mem_stage_pkg::xlen-1:0]       out_pc,
    output logic [31:0]                          out_inst,
    output logic [mem_stage_pkg::op_type_w-1:0]  out_opcode_type,
    output logic [4:0]                           out_rd,
    output logic                                 reg_wen,
    output logic [4:0]                           reg_wr_rd,
    output logic [mem_stage_pkg::xlen-1:0]       reg_wr_value,
    output logic                                 mem_writing_gpr,
    output logic [4:0]                           mem_rd,
    output logic [mem_stage_pkg::xlen-1:0]       mem_alu_out,
    input  logic                                 wb_writing_gpr,
    input  logic [4:0]                           wb_rd,
    input  logic [mem_stage_pkg::xlen-1:0]       wb_wdata
);

    import mem_stage_pkg::*;

    // held record
    logic                 st_valid;
    logic [xlen-1:0]      st_pc;
    logic [31:0]          st_inst;
    logic [op_type_w-1:0] st_opcode_type;
    logic [2:0]           st_funct3;
    logic [4:0]           st_rd;
    logic [xlen-1:0]      st_alu_out;
    logic [xlen-1:0]      st_src2;

    // RAM side
    logic            mem_req;
    logic            mem_we;
    logic [xlen-1:0] mem_addr;
    logic [xlen-1:0] mem_wdata;
    logic [7:0]      mem_wmask;
    logic            mem_ack;
    logic [xlen-1:0] mem_rdata;
    logic [xlen-1:0] load_value;

    logic mem_op;
    logic done;
    logic blocked;
    logic advance;

    // load or store in the stage register
    assign mem_op = st_valid && (st_opcode_type[opt_load] || st_opcode_type[opt_store]);

    // access finished but writeback not yet taken it
    // keeps the result steady under back-pressure
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else if (advance) begin
            done <= 1'b0;
        end else if (mem_ack) begin
            done <= 1'b1;
        end
    end

    // one request per access, dropped once ack or done is seen
    assign mem_req  = mem_op && !mem_ack && !done;
    assign blocked  = mem_req && !mem_ack;
    assign mem_we   = st_opcode_type[opt_store];
    assign mem_addr = st_alu_out;
    assign advance  = in_ready;

    mem_stage_reg u_stage_reg (
        .clk(clk), .rst(rst), .advance(advance),
        .in_valid(in_valid), .pc(pc), .inst(inst), .opcode_type(opcode_type),
        .funct3(funct3), .rd(rd), .rs2(rs2), .alu_out(alu_out), .src2(src2),
        .wb_writing_gpr(wb_writing_gpr), .wb_rd(wb_rd), .wb_wdata(wb_wdata),
        .st_valid(st_valid), .st_pc(st_pc), .st_inst(st_inst),
        .st_opcode_type(st_opcode_type), .st_funct3(st_funct3), .st_rd(st_rd),
        .st_alu_out(st_alu_out), .st_src2(st_src2)
    );

    store_align u_store_align (
        .addr(st_alu_out[2:0]), .src2(st_src2), .funct3(st_funct3),
        .wdata(mem_wdata), .wmask(mem_wmask)
    );

    data_sram #(.ram_words(ram_words)) u_data_sram (
        .clk(clk), .rst(rst), .req(mem_req), .we(mem_we), .addr(mem_addr),
        .wdata(mem_wdata), .wmask(mem_wmask), .ack(mem_ack), .rdata(mem_rdata)
    );

    load_align u_load_align (
        .addr(st_alu_out[2:0]), .rdata(mem_rdata), .funct3(st_funct3),
        .load_value(load_value)
    );

    wb_select u_wb_select (
        .st_valid(st_valid), .st_opcode_type(st_opcode_type), .st_pc(st_pc),
        .st_inst(st_inst), .st_rd(st_rd), .st_alu_out(st_alu_out),
        .st_src2(st_src2), .load_value(load_value), .blocked(blocked),
        .out_ready(out_ready), .in_ready(in_ready), .out_valid(out_valid),
        .out_pc(out_pc), .out_inst(out_inst), .out_opcode_type(out_opcode_type),
        .out_rd(out_rd), .reg_wen(reg_wen), .reg_wr_rd(reg_wr_rd),
        .reg_wr_value(reg_wr_value), .mem_writing_gpr(mem_writing_gpr),
        .mem_rd(mem_rd), .mem_alu_out(mem_alu_out)
    );

    // natural alignment of stores reaching the RAM, no trap logic here
    a_store_aligned: assert property (
        @(posedge clk) disable iff (rst)
        (mem_req && mem_we) |->
            !((st_funct3 == f3_h && st_alu_out[0]) ||
              (st_funct3 == f3_w && st_alu_out[1:0] != 2'b00))
    );

endmodule

// File: design/store_align.sv
/*
 * store data alignment
 * moves the byte, half, word or doubleword of the store operand into
 * its byte lanes and builds the matching byte-write mask
 */
`timescale 1ns/1ns

module store_align (
    input  logic [2:0]                     addr,
    input  logic [mem_stage_pkg::xlen-1:0] src2,
    input  logic [2:0]                     funct3,
    output logic [mem_stage_pkg::xlen-1:0] wdata,
    output logic [7:0]                     wmask
);

    import mem_stage_pkg::*;

    // operand and mask sitting at lane 0
    logic [xlen-1:0] base_data;
    logic [7:0]      base_mask;

    always_comb begin
        case (funct3)
            f3_b: begin
                base_data = {{(xlen-8){1'b0}}, src2[7:0]};
                base_mask = 8'h01;
            end
            f3_h: begin
                base_data = {{(xlen-16){1'b0}}, src2[15:0]};
                base_mask = 8'h03;
            end
            f3_w: begin
                base_data = {{(xlen-32){1'b0}}, src2[31:0]};
                base_mask = 8'h0f;
            end
            f3_d: begin
                base_data = src2;
                base_mask = 8'hff;
            end
            // unsigned codes do not exist for stores
            default: begin
                base_data = '0;
                base_mask = 8'h00;
            end
        endcase
    end

    // shift up to the addressed byte offset
    // bytes past lane 7 fall off, no split access
    assign wdata = base_data << {addr, 3'b000};
    assign wmask = base_mask << addr;

endmodule

// File: design/wb_select.sv
/*
 * writeback selection
 * merges load result, ALU result and src2, gates the stage outputs
 * during a memory stall and drives the hazard signals for decode
 */
`timescale 1ns/1ns

module wb_select (
    input  logic                                 st_valid,
    input  logic [mem_stage_pkg::op_type_w-1:0]  st_opcode_type,
    input  logic [mem_stage_pkg::xlen-1:0]       st_pc,
    input  logic [31:0]                          st_inst,
    input  logic [4:0]                           st_rd,
    input  logic [mem_stage_pkg::xlen-1:0]       st_alu_out,
    input  logic [mem_stage_pkg::xlen-1:0]       st_src2,
    input  logic [mem_stage_pkg::xlen-1:0]       load_value,
    input  logic                                 blocked,
    input  logic                                 out_ready,
    output logic                                 in_ready,
    output logic                                 out_valid,
    output logic [mem_stage_pkg::xlen-1:0]       out_pc,
    output logic [31:0]                          out_inst,
    output logic [mem_stage_pkg::op_type_w-1:0]  out_opcode_type,
    output logic [4:0]                           out_rd,
    output logic                                 reg_wen,
    output logic [4:0]                           reg_wr_rd,
    output logic [mem_stage_pkg::xlen-1:0]       reg_wr_value,
    output logic                                 mem_writing_gpr,
    output logic [4:0]                           mem_rd,
    output logic [mem_stage_pkg::xlen-1:0]       mem_alu_out
);

    import mem_stage_pkg::*;

    logic            writes_gpr;
    logic            wr_live;
    logic [xlen-1:0] result;

    // opcode type lands in the register-writing set
    assign writes_gpr = |(st_opcode_type & gpr_write_mask);

    // load data, then move-src2, else the ALU result
    assign result = st_opcode_type[opt_load]      ? load_value :
                    st_opcode_type[opt_move_src2] ? st_src2    :
                                                    st_alu_out;

    // register write port, quiet while waiting on the RAM
    assign wr_live      = st_valid && !blocked && writes_gpr;
    assign reg_wen      = wr_live;
    assign reg_wr_rd    = wr_live ? st_rd : 5'd0;
    assign reg_wr_value = wr_live ? result : '0;

    // downstream record, zeroed during a stall
    assign out_valid       = blocked ? 1'b0 : st_valid;
    assign out_pc          = blocked ? '0 : st_pc;
    assign out_inst        = blocked ? 32'd0 : st_inst;
    assign out_opcode_type = blocked ? '0 : st_opcode_type;
    assign out_rd          = blocked ? 5'd0 : st_rd;

    // upstream stalls with the stage or with writeback
    assign in_ready = blocked ? 1'b0 : out_ready;

    // interlock info for decode, visible through the stall too
    assign mem_writing_gpr = st_valid && writes_gpr;
    assign mem_rd          = st_rd;
    assign mem_alu_out     = st_alu_out;

endmodule

// File: list.f
+incdir+testbench
design/mem_stage_pkg.sv
design/mem_stage_reg.sv
design/store_align.sv
design/load_align.sv
design/data_sram.sv
design/wb_select.sv
design/mem_stage_top.sv
testbench/mem_stage_tb.sv

// File: run.sh
#!/bin/sh
# build and run the memory-stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ns -f list.f \
    --top-module mem_stage_tb -o mem_stage_sim
./obj_dir/mem_stage_sim | tee sim.log
if grep -q "TB FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    echo "simulation ended without a result line"
    exit 1
fi
echo "simulation ok"

// File: testbench/mem_stage_tasks.svh
/*
 * memory-stage test tasks
 * record issue, store/load/plain-record checks, test sequences
 * and the byte-addressed reference image of the data RAM
 */

// reference image with one entry per byte address
logic [7:0] ref_mem [int];

function automatic logic [63:0] rand64();
    return {$urandom, $urandom};
endfunction

// n little-endian bytes from the image extended per funct3
function automatic logic [63:0] expect_load(input int addr, input logic [2:0] f3);
    int          n;
    logic [63:0] val;
    n   = 1 << f3[1:0];
    val = '0;
    for (int i = 0; i < n; i++) begin
        val = val | (64'(ref_mem[addr + i]) << (8 * i));
    end
    // signed codes copy the field's top bit
    if (!f3[2] && n < 8 && ((val >> (8 * n - 1)) & 64'd1) != 64'd0) begin
        val = val | ({64{1'b1}} << (8 * n));
    end
    return val;
endfunction

task automatic ref_store(input int addr, input logic [2:0] f3, input logic [63:0] data);
    for (int i = 0; i < (1 << f3[1:0]); i++) begin
        ref_mem[addr + i] = 8'(data >> (8 * i));
    end
endtask

// issues one record and returns 2 ns after the accepting edge
task automatic issue(input logic [14:0] op, input logic [2:0] f3, input logic [4:0] rd_i,
                     input logic [4:0] rs2_i, input logic [63:0] alu, input logic [63:0] s2);
    @(posedge clk);
    #2;
    last_pc     = rand64();
    last_inst   = $urandom;
    in_valid    = 1'b1;
    pc          = last_pc;
    inst        = last_inst;
    opcode_type = op;
    funct3      = f3;
    rd          = rd_i;
    rs2         = rs2_i;
    alu_out     = alu;
    src2        = s2;
    @(negedge clk);
    while (!in_ready) begin
        @(negedge clk);
    end
    @(posedge clk);
    #2;
    // bubble behind it
    in_valid    = 1'b0;
    opcode_type = '0;
    rd          = '0;
    rs2         = '0;
endtask

task automatic do_store(input int addr, input logic [2:0] f3, input logic [63:0] data,
                        input logic [4:0] rs2_i);
    issue(op_store, f3, 5'd0, rs2_i, 64'(addr), data);
    // RAM busy and stage outputs hidden
    @(negedge clk);
    check("out_valid", 64'(out_valid), 64'd0);
    check("in_ready", 64'(in_ready), 64'd0);
    check("mem_writing_gpr", 64'(mem_writing_gpr), 64'd0);
    @(negedge clk);
    check("out_valid", 64'(out_valid), 64'd1);
    check("reg_wen", 64'(reg_wen), 64'd0);
    check("out_pc", out_pc, last_pc);
    ref_store(addr, f3, data);
endtask

task automatic do_load(input int addr, input logic [2:0] f3);
    logic [63:0] exp;
    logic [4:0]  rd_i;
    exp  = expect_load(addr, f3);
    rd_i = 5'($urandom % 31 + 1);
    issue(op_load, f3, rd_i, 5'd0, 64'(addr), rand64());
    // hazard info still visible in the blocked cycle
    @(negedge clk);
    check("out_valid", 64'(out_valid), 64'd0);
    check("out_rd", 64'(out_rd), 64'd0);
    check("reg_wen", 64'(reg_wen), 64'd0);
    check("mem_writing_gpr", 64'(mem_writing_gpr), 64'd1);
    check("mem_rd", 64'(mem_rd), 64'(rd_i));
    check("mem_alu_out", mem_alu_out, 64'(addr));
    // two cycles after acceptance
    @(negedge clk);
    check("out_valid", 64'(out_valid), 64'd1);
    check("reg_wen", 64'(reg_wen), 64'd1);
    check("reg_wr_rd", 64'(reg_wr_rd), 64'(rd_i));
    check("reg_wr_value", reg_wr_value, exp);
    check("out_inst", 64'(out_inst), 64'(last_inst));
    check("out_rd", 64'(out_rd), 64'(rd_i));
endtask

// non-memory record visible one cycle after acceptance
task automatic do_plain(input logic [14:0] op, input logic [63:0] alu, input logic [63:0] s2,
                        input logic [4:0] rs2_i, input logic exp_wen, input logic [63:0] exp);
    logic [4:0] rd_i;
    rd_i = 5'($urandom % 31 + 1);
    issue(op, 3'd0, rd_i, rs2_i, alu, s2);
    @(negedge clk);
    check("out_valid", 64'(out_valid), 64'd1);
    check("reg_wen", 64'(reg_wen), 64'(exp_wen));
    check("reg_wr_rd", 64'(reg_wr_rd), exp_wen ? 64'(rd_i) : 64'd0);
    check("reg_wr_value", reg_wr_value, exp_wen ? exp : 64'd0);
    check("mem_writing_gpr", 64'(mem_writing_gpr), 64'(exp_wen));
    check("mem_rd", 64'(mem_rd), 64'(rd_i));
    check("mem_alu_out", mem_alu_out, alu);
    check("out_opcode_type", 64'(out_opcode_type), 64'(op));
    check("out_rd", 64'(out_rd), 64'(rd_i));
endtask

task automatic reset_checks();
    @(negedge clk);
    check("out_valid", 64'(out_valid), 64'd0);
    check("reg_wen", 64'(reg_wen), 64'd0);
    check("mem_writing_gpr", 64'(mem_writing_gpr), 64'd0);
    check("in_ready", 64'(in_ready), 64'd1);
    @(posedge clk);
    #2;
    out_ready = 1'b0;
    @(negedge clk);
    check("in_ready", 64'(in_ready), 64'd0);
    @(posedge clk);
    #2;
    out_ready = 1'b1;
endtask

// every width at every aligned offset inside a freshly written doubleword
task automatic store_load_sweep();
    int base;
    int n;
    for (int w = 0; w < 4; w++) begin
        n = 1 << w;
        for (int off = 0; off < 8; off += n) begin
            base = 8 * int'($urandom % 512);
            do_store(base, f3_d, rand64(), 5'd0);
            do_store(base + off, 3'(w), rand64(), 5'd0);
            do_load(base + off, 3'(w));
            if (w < 3) begin
                do_load(base + off, 3'(w + 4));
            end
            // lanes outside the mask kept
            do_load(base, f3_d);
        end
    end
endtask

task automatic non_memory_checks();
    logic [63:0] v;
    v = rand64();
    do_plain(op_alu, v, rand64(), 5'd0, 1'b1, v);
    v = rand64();
    do_plain(op_mv, rand64(), v, 5'd0, 1'b1, v);
    do_plain(op_branch, rand64(), rand64(), 5'd0, 1'b0, 64'd0);
endtask

task automatic forwarding_checks();
    int          base;
    int          base2;
    logic [63:0] fwd;
    base  = 8 * int'($urandom % 512);
    base2 = 8 * int'(($urandom % 511 + 1 + base / 8) % 512);
    fwd   = rand64();
    @(posedge clk);
    #2;
    // writeback writing x7 while the record reads x7
    wb_writing_gpr = 1'b1;
    wb_rd          = 5'd7;
    wb_wdata       = fwd;
    do_store(base, f3_d, rand64(), 5'd7);
    // the writeback value lands in place of the stale operand
    ref_store(base, f3_d, fwd);
    do_plain(op_mv, rand64(), rand64(), 5'd7, 1'b1, fwd);
    @(posedge clk);
    #2;
    // x0 never forwards
    wb_rd = 5'd0;
    do_store(base2, f3_d, rand64(), 5'd0);
    @(posedge clk);
    #2;
    wb_writing_gpr = 1'b0;
    wb_wdata       = '0;
    do_load(base, f3_d);
    do_load(base2, f3_d);
endtask

// writeback stalls a finished load whose result must hold
task automatic back_pressure_checks();
    int          base;
    logic [63:0] exp;
    base = 8 * int'($urandom % 512);
    do_store(base, f3_d, rand64(), 5'd0);
    exp = expect_load(base + 4, f3_w);
    issue(op_load, f3_w, 5'd9, 5'd0, 64'(base + 4), rand64());
    out_ready = 1'b0;
    @(negedge clk);
    check("out_valid", 64'(out_valid), 64'd0);
    check("in_ready", 64'(in_ready), 64'd0);
    repeat (4) begin
        @(negedge clk);
        check("in_ready", 64'(in_ready), 64'd0);
        check("out_valid", 64'(out_valid), 64'd1);
        check("reg_wr_rd", 64'(reg_wr_rd), 64'd9);
        check("reg_wr_value", reg_wr_value, exp);
    end
    @(posedge clk);
    #2;
    out_ready = 1'b1;
    @(negedge clk);
    check("in_ready", 64'(in_ready), 64'd1);
    check("reg_wr_value", reg_wr_value, exp);
    // bubble taken at the next edge
    @(negedge clk);
    check("out_valid", 64'(out_valid), 64'd0);
endtask

// File: testbench/mem_stage_tb.sv
/*
 * memory-stage testbench
 * directed store/load, ALU, forwarding and back-pressure tests
 * against a byte-level reference image of the data RAM
 */
`timescale 1ns/1ns

module mem_stage_tb;

    import mem_stage_pkg::*;

    // the directed tests need a few hundred cycles
    localparam int test_cycles = 400;
    localparam int max_cycles  = 5 * test_cycles;

    // one-hot opcode types used by the tests
    localparam logic [14:0] op_alu    = 15'h0001;
    localparam logic [14:0] op_load   = 15'h0020;
    localparam logic [14:0] op_store  = 15'h0040;
    localparam logic [14:0] op_mv     = 15'h0800;
    // branch type, bit 12, writes no register
    localparam logic [14:0] op_branch = 15'h1000;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic        in_ready;
    logic [63:0] pc;
    logic [31:0] inst;
    logic [14:0] opcode_type;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [63:0] alu_out;
    logic [63:0] src2;
    logic        out_valid;
    logic        out_ready;
    logic [63:0] out_pc;
    logic [31:0] out_inst;
    logic [14:0] out_opcode_type;
    logic [4:0]  out_rd;
    logic        reg_wen;
    logic [4:0]  reg_wr_rd;
    logic [63:0] reg_wr_value;
    logic        mem_writing_gpr;
    logic [4:0]  mem_rd;
    logic [63:0] mem_alu_out;
    logic        wb_writing_gpr;
    logic [4:0]  wb_rd;
    logic [63:0] wb_wdata;

    int          errors;
    int          cycle_count;
    // last record sent, for the out_* checks
    logic [63:0] last_pc;
    logic [31:0] last_inst;

    mem_stage_top #(.ram_words(512)) mem_stage_top_i (.*);

    always #20 clk = ~clk;

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    `include "mem_stage_tasks.svh"

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: tests did not finish within %0d cycles", max_cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hd402_612a));
        errors         = 0;
        clk            = 1'b0;
        rst            = 1'b1;
        in_valid       = 1'b0;
        pc             = '0;
        inst           = '0;
        opcode_type    = '0;
        funct3         = '0;
        rd             = '0;
        rs2            = '0;
        alu_out        = '0;
        src2           = '0;
        out_ready      = 1'b1;
        wb_writing_gpr = 1'b0;
        wb_rd          = '0;
        wb_wdata       = '0;
        // two cycles of reset
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        reset_checks();
        store_load_sweep();
        non_memory_checks();
        forwarding_checks();
        back_pressure_checks();
        @(posedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
